// ==== asic_gpio_top.f ====
logic/amba_pkg.sv
logic/soc_map_pkg.sv
logic/apb_if.sv
logic/host_apb_bridge.sv
logic/apb_splitter.sv
logic/prci_ctrl.sv
logic/apb_gpio.sv
logic/asic_gpio_top.sv
bench/tb_asic_gpio_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_asic_gpio_top -f asic_gpio_top.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1

grep -q "^NO ERRORS$" sim.log && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== bench/tb_asic_gpio_top.sv ====
`timescale 1ns/100ps
// Testbench for the GPIO subsystem chip top
//
// Directed tests through the debug host port: reset release, GPIO output,
// GPIO input, soft reset, PLL lock loss and an unmapped access.
// Random data and pin values come from a Galois LFSR.

module tb_asic_gpio_top;

    localparam int CLK_HALF = 2;
    localparam int LOCK_FILTER_CYCLES = 16;
    localparam int SOFT_RST_CYCLES = 8;
    localparam int HOST_LATENCY = 3;
    // Generous cycle budget per test, watchdog at 1.5 times the sum
    localparam int TEST_COUNT = 6;
    localparam int CYCLES_PER_TEST = 440;
    localparam int WATCHDOG_CYCLES = (8 + TEST_COUNT * CYCLES_PER_TEST) * 3 / 2;

    // Register addresses as seen from the host
    localparam logic [11:0] PRCI_CTRL   = 12'h000;
    localparam logic [11:0] PRCI_STATUS = 12'h004;
    localparam logic [11:0] PRCI_CAUSE  = 12'h008;
    localparam logic [11:0] GPIO_DIR    = 12'h100;
    localparam logic [11:0] GPIO_OUT    = 12'h104;
    localparam logic [11:0] GPIO_IN     = 12'h108;
    localparam logic [11:0] UNMAPPED    = 12'h300;
    localparam logic [31:0] CAUSE_POR_M  = 32'h1;
    localparam logic [31:0] CAUSE_SOFT_M = 32'h2;
    localparam logic [31:0] CAUSE_LOSS_M = 32'h4;

    logic        i_sclk;
    logic        i_rst_n;
    logic        i_pll_lock;
    logic        i_host_req;
    logic        i_host_write;
    logic [11:0] i_host_addr;
    logic [31:0] i_host_wdata;
    logic        o_host_done;
    logic [31:0] o_host_rdata;
    logic        o_host_err;
    logic [11:0] i_gpio;
    logic [11:0] o_gpio;
    logic [11:0] o_gpio_oe;
    logic        o_sys_nrst;
    logic        o_pll_locked_led;

    int          errors;
    int          failed_tests;
    logic [15:0] lfsr_q;

    asic_gpio_top #(
        .LOCK_FILTER_CYCLES (LOCK_FILTER_CYCLES),
        .SOFT_RST_CYCLES    (SOFT_RST_CYCLES),
        .GPIO_WIDTH         (12)
    ) dut_i (
        .i_sclk           (i_sclk),
        .i_rst_n          (i_rst_n),
        .i_pll_lock       (i_pll_lock),
        .i_host_req       (i_host_req),
        .i_host_write     (i_host_write),
        .i_host_addr      (i_host_addr),
        .i_host_wdata     (i_host_wdata),
        .o_host_done      (o_host_done),
        .o_host_rdata     (o_host_rdata),
        .o_host_err       (o_host_err),
        .i_gpio           (i_gpio),
        .o_gpio           (o_gpio),
        .o_gpio_oe        (o_gpio_oe),
        .o_sys_nrst       (o_sys_nrst),
        .o_pll_locked_led (o_pll_locked_led)
    );

    initial begin
        i_sclk = 1'b0;
        forever #CLK_HALF i_sclk = ~i_sclk;
    end

    // 16-bit Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
        errors++;
    endtask

    // Drives one host request and returns in the cycle that shows done
    task automatic host_xfer(input logic wr, input logic [11:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
        int   cycles;
        logic got;
        cycles = 0;
        got    = 1'b0;
        @(posedge i_sclk);
        i_host_req   <= 1'b1;
        i_host_write <= wr;
        i_host_addr  <= addr;
        i_host_wdata <= wdata;
        while (!got && cycles < 10) begin
            @(posedge i_sclk);
            i_host_req <= 1'b0;
            cycles++;
            @(negedge i_sclk);
            got = o_host_done;
        end
        rdata = o_host_rdata;
        err   = o_host_err;
        if (!got) begin
            $display("Error at %0t: no host done within 10 cycles of a request to 0x%0h",
                     $time, addr);
            errors++;
        end else if (cycles != HOST_LATENCY) begin
            report_mismatch("host done latency", HOST_LATENCY, cycles);
        end
    endtask

    task automatic host_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        host_xfer(1'b1, addr, data, rdata, err);
        if (err !== 1'b0) begin
            report_mismatch("o_host_err", 32'h0, 32'(err));
        end
    endtask

    task automatic host_read(input logic [11:0] addr, output logic [31:0] data,
                             output logic err);
        host_xfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic read_check(input logic [11:0] addr, input logic [31:0] exp,
                              input string name);
        logic [31:0] data;
        logic        err;
        host_read(addr, data, err);
        if (err !== 1'b0) begin
            report_mismatch("o_host_err", 32'h0, 32'(err));
        end
        if (data !== exp) begin
            report_mismatch(name, exp, data);
        end
    endtask

    // Counts sampled cycles with o_sys_nrst low, starting at the next negedge
    task automatic count_until_release(output int n);
        n = 0;
        forever begin
            @(negedge i_sclk);
            if (o_sys_nrst === 1'b1 || n > 200) begin
                break;
            end
            n++;
        end
        if (n > 200) begin
            $display("Error at %0t: o_sys_nrst never released", $time);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("Test %s: pass", name);
        end else begin
            $display("Test %s: fail", name);
            failed_tests++;
        end
    endtask

    task automatic test_reset_release();
        int start;
        int n;
        start = errors;
        repeat (7) @(posedge i_sclk);
        @(negedge i_sclk);
        if (o_host_done !== 1'b0) report_mismatch("o_host_done", 32'h0, 32'(o_host_done));
        if (o_sys_nrst !== 1'b0) report_mismatch("o_sys_nrst", 32'h0, 32'(o_sys_nrst));
        if (o_gpio_oe !== 12'h0) report_mismatch("o_gpio_oe", 32'h0, 32'(o_gpio_oe));
        if (o_gpio !== 12'h0) report_mismatch("o_gpio", 32'h0, 32'(o_gpio));
        if (dut_i.bus_host.psel !== 1'b0 || dut_i.bus_host.penable !== 1'b0) begin
            report_mismatch("psel/penable", 32'h0,
                            {30'h0, dut_i.bus_host.psel, dut_i.bus_host.penable});
        end
        @(posedge i_sclk);
        i_rst_n <= 1'b1;
        // No lock yet, so the system must stay in reset
        repeat (4) begin
            @(negedge i_sclk);
            if (o_sys_nrst !== 1'b0) report_mismatch("o_sys_nrst", 32'h0, 32'(o_sys_nrst));
        end
        @(posedge i_sclk);
        i_pll_lock <= 1'b1;
        count_until_release(n);
        if (n != LOCK_FILTER_CYCLES) report_mismatch("lock filter cycles", 16, 32'(n));
        read_check(PRCI_STATUS, 32'h3, "PRCI_STATUS");
        read_check(PRCI_CAUSE, CAUSE_POR_M, "PRCI_CAUSE");
        host_write(PRCI_CAUSE, CAUSE_POR_M);
        read_check(PRCI_CAUSE, 32'h0, "PRCI_CAUSE");
        finish_test("reset_release", start);
    endtask

    task automatic test_gpio_output();
        int          start;
        logic [31:0] dir;
        logic [31:0] out;
        start = errors;
        for (int k = 0; k < 3; k++) begin
            draw_bits(12, dir);
            draw_bits(12, out);
            host_write(GPIO_DIR, dir);
            host_write(GPIO_OUT, out);
            if (o_gpio_oe !== dir[11:0]) report_mismatch("o_gpio_oe", dir, 32'(o_gpio_oe));
            if (o_gpio !== (out[11:0] & dir[11:0])) begin
                report_mismatch("o_gpio", out & dir, 32'(o_gpio));
            end
            read_check(GPIO_DIR, dir, "GPIO_DIR");
            read_check(GPIO_OUT, out, "GPIO_OUT");
        end
        finish_test("gpio_output", start);
    endtask

    task automatic test_gpio_input();
        int          start;
        logic [31:0] pins;
        start = errors;
        for (int k = 0; k < 4; k++) begin
            draw_bits(12, pins);
            @(posedge i_sclk);
            i_gpio <= pins[11:0];
            // Two synchroniser flops plus margin
            repeat (3) @(posedge i_sclk);
            read_check(GPIO_IN, pins, "GPIO_IN");
        end
        finish_test("gpio_input", start);
    endtask

    task automatic test_soft_reset();
        int start;
        int n;
        start = errors;
        host_write(PRCI_CTRL, 32'h1);
        if (o_sys_nrst !== 1'b0) report_mismatch("o_sys_nrst", 32'h0, 32'(o_sys_nrst));
        count_until_release(n);
        // The host write returns in the first held cycle
        if (n + 1 != SOFT_RST_CYCLES + LOCK_FILTER_CYCLES) begin
            report_mismatch("soft reset low cycles", 24, 32'(n + 1));
        end
        if (o_gpio_oe !== 12'h0) report_mismatch("o_gpio_oe", 32'h0, 32'(o_gpio_oe));
        read_check(GPIO_DIR, 32'h0, "GPIO_DIR");
        read_check(GPIO_OUT, 32'h0, "GPIO_OUT");
        read_check(PRCI_CAUSE, CAUSE_SOFT_M, "PRCI_CAUSE");
        host_write(PRCI_CAUSE, 32'h7);
        read_check(PRCI_CAUSE, 32'h0, "PRCI_CAUSE");
        finish_test("soft_reset", start);
    endtask

    task automatic test_lock_loss();
        int start;
        int n;
        start = errors;
        @(posedge i_sclk);
        i_pll_lock <= 1'b0;
        @(posedge i_sclk);
        @(negedge i_sclk);
        if (o_sys_nrst !== 1'b0) report_mismatch("o_sys_nrst", 32'h0, 32'(o_sys_nrst));
        if (o_pll_locked_led !== 1'b0) begin
            report_mismatch("o_pll_locked_led", 32'h0, 32'(o_pll_locked_led));
        end
        repeat (3) @(posedge i_sclk);
        i_pll_lock <= 1'b1;
        count_until_release(n);
        if (n != LOCK_FILTER_CYCLES) report_mismatch("lock filter cycles", 16, 32'(n));
        if (o_pll_locked_led !== 1'b1) begin
            report_mismatch("o_pll_locked_led", 32'h1, 32'(o_pll_locked_led));
        end
        read_check(PRCI_CAUSE, CAUSE_LOSS_M, "PRCI_CAUSE");
        read_check(PRCI_STATUS, 32'h3, "PRCI_STATUS");
        finish_test("lock_loss", start);
    endtask

    task automatic test_unmapped();
        int          start;
        logic [31:0] data;
        logic        err;
        start = errors;
        host_read(UNMAPPED, data, err);
        if (err !== 1'b1) report_mismatch("o_host_err", 32'h1, 32'(err));
        if (data !== 32'h0) report_mismatch("o_host_rdata", 32'h0, data);
        // Mapped neighbours answer without error
        read_check(PRCI_STATUS, 32'h3, "PRCI_STATUS");
        read_check(GPIO_DIR, 32'h0, "GPIO_DIR");
        finish_test("unmapped", start);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_sclk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        errors       = 0;
        failed_tests = 0;
        lfsr_q       = 16'd62;
        i_rst_n      = 1'b0;
        i_pll_lock   = 1'b0;
        i_host_req   = 1'b0;
        i_host_write = 1'b0;
        i_host_addr  = '0;
        i_host_wdata = '0;
        i_gpio       = '0;
        test_reset_release();
        test_gpio_output();
        test_gpio_input();
        test_soft_reset();
        test_lock_loss();
        test_unmapped();
        $display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
                 TEST_COUNT, failed_tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== logic/asic_gpio_top.sv ====
`timescale 1ns/100ps
// Chip top of the GPIO subsystem
//
// A debug host drives APB through the bridge. The decoder splits the bus
// between the PLL/reset controller and the GPIO block. The GPIO runs on
// the system reset that the controller generates.

module asic_gpio_top #(
    parameter int LOCK_FILTER_CYCLES = 16,
    parameter int SOFT_RST_CYCLES    = 8,
    parameter int GPIO_WIDTH         = 12
) (
    input  logic                   i_sclk,
    input  logic                   i_rst_n,
    input  logic                   i_pll_lock,
    // Debug host port
    input  logic                   i_host_req,
    input  logic                   i_host_write,
    input  amba_pkg::apb_addr_t    i_host_addr,
    input  amba_pkg::apb_data_t    i_host_wdata,
    output logic                   o_host_done,
    output amba_pkg::apb_data_t    o_host_rdata,
    output logic                   o_host_err,
    // GPIO pads split into input, output and enable
    input  soc_map_pkg::gpio_vec_t i_gpio,
    output soc_map_pkg::gpio_vec_t o_gpio,
    output soc_map_pkg::gpio_vec_t o_gpio_oe,
    // Reset and lock status
    output logic                   o_sys_nrst,
    output logic                   o_pll_locked_led
);

    apb_if bus_host (.pclk(i_sclk));
    apb_if bus_prci (.pclk(i_sclk));
    apb_if bus_gpio (.pclk(i_sclk));

    host_apb_bridge bridge0 (
        .i_sclk       (i_sclk),
        .i_rst_n      (i_rst_n),
        .i_host_req   (i_host_req),
        .i_host_write (i_host_write),
        .i_host_addr  (i_host_addr),
        .i_host_wdata (i_host_wdata),
        .o_host_done  (o_host_done),
        .o_host_rdata (o_host_rdata),
        .o_host_err   (o_host_err),
        .m            (bus_host.master)
    );

    apb_splitter split0 (
        .s      (bus_host.slave),
        .m_prci (bus_prci.master),
        .m_gpio (bus_gpio.master)
    );

    prci_ctrl #(
        .LOCK_FILTER_CYCLES (LOCK_FILTER_CYCLES),
        .SOFT_RST_CYCLES    (SOFT_RST_CYCLES)
    ) prci0 (
        .i_sclk           (i_sclk),
        .i_rst_n          (i_rst_n),
        .i_pll_lock       (i_pll_lock),
        .o_sys_nrst       (o_sys_nrst),
        .o_pll_locked_led (o_pll_locked_led),
        .s                (bus_prci.slave)
    );

    // Peripheral reset comes from the sequencer, not from the pin
    apb_gpio #(
        .GPIO_WIDTH (GPIO_WIDTH)
    ) gpio0 (
        .i_sclk     (i_sclk),
        .i_sys_nrst (o_sys_nrst),
        .i_gpio     (i_gpio),
        .o_gpio     (o_gpio),
        .o_gpio_oe  (o_gpio_oe),
        .s          (bus_gpio.slave)
    );

endmodule

// ==== logic/apb_gpio.sv ====
`timescale 1ns/100ps
// GPIO controller
//
// Direction and output registers plus a two-flop input synchroniser,
// all mapped on APB. Pins above GPIO_WIDTH read and drive zero. Output
// values reach a pin only where its direction bit is set.

module apb_gpio #(
    parameter int GPIO_WIDTH = 12
) (
    input  logic                   i_sclk,
    input  logic                   i_sys_nrst,
    input  soc_map_pkg::gpio_vec_t i_gpio,
    output soc_map_pkg::gpio_vec_t o_gpio,
    output soc_map_pkg::gpio_vec_t o_gpio_oe,
    apb_if.slave                   s
);
    typedef logic [GPIO_WIDTH-1:0] pins_t;

    pins_t                 dir_q;
    pins_t                 out_q;
    pins_t                 sync1_q;
    pins_t                 sync2_q;
    soc_map_pkg::reg_ofs_t ofs;
    logic                  wr_en;

    assign ofs   = s.paddr[soc_map_pkg::REGION_LSB-1:0];
    assign wr_en = s.psel && s.penable && s.pwrite;

    always_ff @(posedge i_sclk) begin
        if (!i_sys_nrst) begin
            dir_q <= '0;
            out_q <= '0;
        end else if (wr_en) begin
            // GPIO_IN is read only and ignores writes
            if (ofs == soc_map_pkg::GPIO_DIR_OFS) begin
                dir_q <= s.pwdata[GPIO_WIDTH-1:0];
            end
            if (ofs == soc_map_pkg::GPIO_OUT_OFS) begin
                out_q <= s.pwdata[GPIO_WIDTH-1:0];
            end
        end
    end

    // Pads are asynchronous to i_sclk
    always_ff @(posedge i_sclk) begin
        sync1_q <= i_gpio[GPIO_WIDTH-1:0];
        sync2_q <= sync1_q;
    end

    always_comb begin
        case (ofs)
            soc_map_pkg::GPIO_DIR_OFS: s.prdata = amba_pkg::apb_data_t'(dir_q);
            soc_map_pkg::GPIO_OUT_OFS: s.prdata = amba_pkg::apb_data_t'(out_q);
            soc_map_pkg::GPIO_IN_OFS:  s.prdata = amba_pkg::apb_data_t'(sync2_q);
            default:                   s.prdata = '0;
        endcase
    end

    assign s.pready  = 1'b1;
    assign s.pslverr = 1'b0;

    assign o_gpio_oe = soc_map_pkg::gpio_vec_t'(dir_q);
    assign o_gpio    = soc_map_pkg::gpio_vec_t'(out_q & dir_q);

endmodule

// ==== logic/prci_ctrl.sv ====
`timescale 1ns/100ps
// PLL and reset controller
//
// Releases the system reset once PLL lock has been stable for
// LOCK_FILTER_CYCLES cycles, drops it at once on lock loss and holds it
// for SOFT_RST_CYCLES on a software request. Keeps the last reset causes
// and exposes control, status and cause registers on APB.

module prci_ctrl #(
    parameter int LOCK_FILTER_CYCLES = 16,
    parameter int SOFT_RST_CYCLES    = 8
) (
    input  logic i_sclk,
    input  logic i_rst_n,
    input  logic i_pll_lock,
    output logic o_sys_nrst,
    output logic o_pll_locked_led,
    apb_if.slave s
);
    localparam int LOCK_CNT_W = $clog2(LOCK_FILTER_CYCLES + 1);
    localparam int SOFT_CNT_W = $clog2(SOFT_RST_CYCLES + 1);

    typedef enum logic [1:0] {WAIT_LOCK, RUN, SOFT_HOLD} rst_state_t;
    typedef logic [LOCK_CNT_W-1:0] lock_cnt_t;
    typedef logic [SOFT_CNT_W-1:0] soft_cnt_t;

    rst_state_t            state_q;
    rst_state_t            state_d;
    lock_cnt_t             lock_cnt_q;
    soft_cnt_t             soft_cnt_q;
    logic                  lock_ok_q;
    soc_map_pkg::cause_t   cause_q;
    soc_map_pkg::cause_t   cause_set;
    soc_map_pkg::cause_t   cause_clr;
    soc_map_pkg::reg_ofs_t ofs;
    logic                  wr_en;
    logic                  soft_req;
    logic                  lock_done;
    logic                  soft_done;
    logic                  lock_lost;

    assign ofs       = s.paddr[soc_map_pkg::REGION_LSB-1:0];
    assign wr_en     = s.psel && s.penable && s.pwrite;
    assign soft_req  = wr_en && (ofs == soc_map_pkg::PRCI_CTRL_OFS)
                       && s.pwdata[soc_map_pkg::CTRL_SOFT_BIT];
    assign lock_done = (state_q == WAIT_LOCK) && i_pll_lock
                       && (lock_cnt_q == lock_cnt_t'(LOCK_FILTER_CYCLES - 1));
    assign soft_done = (soft_cnt_q == soft_cnt_t'(SOFT_RST_CYCLES - 1));
    assign lock_lost = (state_q == RUN) && !i_pll_lock;

    always_comb begin
        state_d = state_q;
        if (soft_req) begin
            state_d = SOFT_HOLD;
        end else begin
            case (state_q)
                WAIT_LOCK: state_d = lock_done ? RUN : WAIT_LOCK;
                RUN:       state_d = i_pll_lock ? RUN : WAIT_LOCK;
                SOFT_HOLD: state_d = soft_done ? WAIT_LOCK : SOFT_HOLD;
                default:   state_d = WAIT_LOCK;
            endcase
        end
    end

    always_comb begin
        cause_set = '0;
        cause_set[soc_map_pkg::CAUSE_SOFT]      = soft_req;
        cause_set[soc_map_pkg::CAUSE_LOCK_LOSS] = lock_lost;
        cause_clr = '0;
        if (wr_en && ofs == soc_map_pkg::PRCI_CAUSE_OFS) begin
            cause_clr = s.pwdata[soc_map_pkg::CAUSE_W-1:0];
        end
    end

    always_ff @(posedge i_sclk) begin
        if (!i_rst_n) begin
            state_q    <= WAIT_LOCK;
            lock_cnt_q <= '0;
            soft_cnt_q <= '0;
            lock_ok_q  <= 1'b0;
            cause_q    <= '0;
            cause_q[soc_map_pkg::CAUSE_POR] <= 1'b1;
        end else begin
            state_q <= state_d;
            // Any gap in lock restarts the filter
            if (state_q == WAIT_LOCK && !soft_req && i_pll_lock && !lock_done) begin
                lock_cnt_q <= lock_cnt_q + 1'b1;
            end else begin
                lock_cnt_q <= '0;
            end
            if (state_q == SOFT_HOLD && !soft_req && !soft_done) begin
                soft_cnt_q <= soft_cnt_q + 1'b1;
            end else begin
                soft_cnt_q <= '0;
            end
            if (!i_pll_lock) begin
                lock_ok_q <= 1'b0;
            end else if (lock_done) begin
                lock_ok_q <= 1'b1;
            end
            // New events win over a clear in the same cycle
            cause_q <= (cause_q & ~cause_clr) | cause_set;
        end
    end

    always_comb begin
        s.prdata = '0;
        case (ofs)
            soc_map_pkg::PRCI_CTRL_OFS: begin
                s.prdata[soc_map_pkg::CTRL_SOFT_BIT] = (state_q == SOFT_HOLD);
            end
            soc_map_pkg::PRCI_STATUS_OFS: begin
                s.prdata[soc_map_pkg::STATUS_RUN_BIT]  = o_sys_nrst;
                s.prdata[soc_map_pkg::STATUS_LOCK_BIT] = lock_ok_q;
            end
            soc_map_pkg::PRCI_CAUSE_OFS: begin
                s.prdata[soc_map_pkg::CAUSE_W-1:0] = cause_q;
            end
            default: s.prdata = '0;
        endcase
    end

    assign s.pready         = 1'b1;
    assign s.pslverr        = 1'b0;
    assign o_sys_nrst       = (state_q == RUN);
    assign o_pll_locked_led = lock_ok_q;

    // System never keeps running past the edge that sees lock gone
    a_no_run_unlocked: assert property (
        @(posedge i_sclk) disable iff (!i_rst_n)
        !i_pll_lock |=> !o_sys_nrst
    );

endmodule

// ==== logic/apb_splitter.sv ====
`timescale 1ns/100ps
// APB address decoder
//
// Routes each transfer to the PRCI or the GPIO slave by the region bits
// of paddr and passes only the register offset downstream. Responses are
// muxed back. Unmapped regions complete at once with an error.

module apb_splitter (
    apb_if.slave  s,
    apb_if.master m_prci,
    apb_if.master m_gpio
);
    soc_map_pkg::region_t region;
    amba_pkg::apb_addr_t  ofs_addr;
    logic                 hit_prci;
    logic                 hit_gpio;

    assign region   = s.paddr[amba_pkg::APB_ADDR_W-1:soc_map_pkg::REGION_LSB];
    assign hit_prci = (region == soc_map_pkg::PRCI_REGION);
    assign hit_gpio = (region == soc_map_pkg::GPIO_REGION);
    assign ofs_addr = {soc_map_pkg::region_t'(0), s.paddr[soc_map_pkg::REGION_LSB-1:0]};

    assign m_prci.psel    = s.psel && hit_prci;
    assign m_prci.penable = s.penable && hit_prci;
    assign m_prci.pwrite  = s.pwrite;
    assign m_prci.paddr   = ofs_addr;
    assign m_prci.pwdata  = s.pwdata;

    assign m_gpio.psel    = s.psel && hit_gpio;
    assign m_gpio.penable = s.penable && hit_gpio;
    assign m_gpio.pwrite  = s.pwrite;
    assign m_gpio.paddr   = ofs_addr;
    assign m_gpio.pwdata  = s.pwdata;

    always_comb begin
        if (hit_prci) begin
            s.prdata  = m_prci.prdata;
            s.pready  = m_prci.pready;
            s.pslverr = m_prci.pslverr;
        end else if (hit_gpio) begin
            s.prdata  = m_gpio.prdata;
            s.pready  = m_gpio.pready;
            s.pslverr = m_gpio.pslverr;
        end else begin
            // Nobody home
            s.prdata  = '0;
            s.pready  = 1'b1;
            s.pslverr = 1'b1;
        end
    end

    a_one_slave: assert property (@(posedge s.pclk) m_prci.psel |-> !m_gpio.psel);

    // Upstream must hold the address so the same slave sees the access phase
    a_prci_setup_to_access: assert property (
        @(posedge s.pclk) m_prci.psel && !m_prci.penable |=> m_prci.psel && m_prci.penable
    );

endmodule

// ==== logic/host_apb_bridge.sv ====
`timescale 1ns/100ps
// Debug host to APB bridge
//
// Takes a one-cycle request strobe with address, data and direction,
// runs one APB transfer and answers with a one-cycle done pulse that
// carries the read data and the slave error flag. Requests that arrive
// while a transfer is in flight are ignored.

module host_apb_bridge (
    input  logic                i_sclk,
    input  logic                i_rst_n,
    input  logic                i_host_req,
    input  logic                i_host_write,
    input  amba_pkg::apb_addr_t i_host_addr,
    input  amba_pkg::apb_data_t i_host_wdata,
    output logic                o_host_done,
    output amba_pkg::apb_data_t o_host_rdata,
    output logic                o_host_err,
    apb_if.master               m
);
    typedef enum logic [1:0] {IDLE, SETUP, ACCESS, RESP} state_t;

    state_t              state_q;
    state_t              state_d;
    logic                write_q;
    amba_pkg::apb_addr_t addr_q;
    amba_pkg::apb_data_t wdata_q;
    amba_pkg::apb_data_t rdata_q;
    logic                err_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_host_req) begin
                    state_d = SETUP;
                end
            end
            SETUP:   state_d = ACCESS;
            // Slaves may stretch the access phase with pready
            ACCESS: begin
                if (m.pready) begin
                    state_d = RESP;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge i_sclk) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request is held for the whole transfer
    always_ff @(posedge i_sclk) begin
        if (state_q == IDLE && i_host_req) begin
            write_q <= i_host_write;
            addr_q  <= i_host_addr;
            wdata_q <= i_host_wdata;
        end
        if (state_q == ACCESS && m.pready) begin
            rdata_q <= m.prdata;
            err_q   <= m.pslverr;
        end
    end

    assign m.psel    = (state_q == SETUP) || (state_q == ACCESS);
    assign m.penable = (state_q == ACCESS);
    assign m.pwrite  = write_q;
    assign m.paddr   = addr_q;
    assign m.pwdata  = wdata_q;

    assign o_host_done  = (state_q == RESP);
    assign o_host_rdata = rdata_q;
    assign o_host_err   = err_q;

    // Every access phase belongs to a transfer that already had its setup
    a_access_after_setup: assert property (
        @(posedge i_sclk) disable iff (!i_rst_n)
        m.penable |-> m.psel && $past(m.psel)
    );

endmodule

// ==== logic/apb_if.sv ====
`timescale 1ns/100ps
// APB bus bundle
//
// One instance per bus segment. The bus clock comes in as an interface
// port so that protocol checks can sample on it.

interface apb_if (
    input logic pclk
);
    logic                psel;
    logic                penable;
    logic                pwrite;
    amba_pkg::apb_addr_t paddr;
    amba_pkg::apb_data_t pwdata;
    amba_pkg::apb_data_t prdata;
    logic                pready;
    logic                pslverr;

    modport master (
        input  pclk,
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  pclk,
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready, pslverr
    );

endinterface

// ==== logic/soc_map_pkg.sv ====
// Subsystem address map
//
// Region bases, register offsets and register bit positions for the
// PLL/reset controller and the GPIO block. Address bits 11:8 pick the
// region, the low byte is the register offset inside it.

package soc_map_pkg;

    // Bits at and above REGION_LSB select a slave
    localparam int REGION_LSB = 8;
    typedef logic [amba_pkg::APB_ADDR_W-REGION_LSB-1:0] region_t;
    typedef logic [REGION_LSB-1:0] reg_ofs_t;

    localparam amba_pkg::apb_addr_t PRCI_BASE = 12'h000;
    localparam amba_pkg::apb_addr_t GPIO_BASE = 12'h100;
    localparam region_t PRCI_REGION = PRCI_BASE[amba_pkg::APB_ADDR_W-1:REGION_LSB];
    localparam region_t GPIO_REGION = GPIO_BASE[amba_pkg::APB_ADDR_W-1:REGION_LSB];

    // PRCI registers
    localparam reg_ofs_t PRCI_CTRL_OFS   = 8'h00;
    localparam reg_ofs_t PRCI_STATUS_OFS = 8'h04;
    localparam reg_ofs_t PRCI_CAUSE_OFS  = 8'h08;
    localparam int CTRL_SOFT_BIT   = 0;
    localparam int STATUS_RUN_BIT  = 0;
    localparam int STATUS_LOCK_BIT = 1;

    // Reset cause bits, each one cleared by writing a one
    localparam int CAUSE_W         = 3;
    localparam int CAUSE_POR       = 0;
    localparam int CAUSE_SOFT      = 1;
    localparam int CAUSE_LOCK_LOSS = 2;
    typedef logic [CAUSE_W-1:0] cause_t;

    // GPIO registers
    localparam reg_ofs_t GPIO_DIR_OFS = 8'h00;
    localparam reg_ofs_t GPIO_OUT_OFS = 8'h04;
    localparam reg_ofs_t GPIO_IN_OFS  = 8'h08;

    // Pins on the chip boundary
    localparam int GPIO_PINS = 12;
    typedef logic [GPIO_PINS-1:0] gpio_vec_t;

endpackage

// ==== logic/amba_pkg.sv ====
// AMBA APB bus definitions
//
// Address and data widths of the internal APB that links the debug host
// bridge, the address decoder and the register-mapped peripherals.
// Byte addressing, one 32-bit register every four bytes.

package amba_pkg;

    // 4 KB of register space covers every region of the subsystem
    localparam int APB_ADDR_W = 12;

    // Full word data path, no byte strobes
    localparam int APB_DATA_W = 32;

    // Byte address on paddr
    typedef logic [APB_ADDR_W-1:0] apb_addr_t;

    // Read and write data words
    typedef logic [APB_DATA_W-1:0] apb_data_t;

endpackage
